/* source/l2_cache_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~
// l2 cache shared definitions
// address, line and counter widths and types,
// controller state encoding
// ~~~~~~~~~~~~~~~~~~~~

`default_nettype none

package l2_cache_pkg;

    // byte address
    localparam int unsigned ADDR_WIDTH = 32;

    // byte offset below the set index, ignored by the cache
    localparam int unsigned OFFSET_BITS = 2;

    // one line is a single word
    localparam int unsigned LINE_WIDTH = 32;

    // statistics counters
    localparam int unsigned COUNT_WIDTH = 32;

    typedef logic [ADDR_WIDTH-1:0]  addr_t;   // byte address
    typedef logic [LINE_WIDTH-1:0]  line_t;   // cache line payload
    typedef logic [COUNT_WIDTH-1:0] count_t;  // counter value

    // controller FSM states
    typedef enum logic [1:0] {
        IDLE,         // waiting for a request
        COMPARE_TAG,  // tag check, hit response or miss dispatch
        ALLOCATE,     // waiting for the refill read
        WRITE_BACK    // waiting for the victim write
    } cache_state_e;

endpackage

`default_nettype wire

/* source/l2_array_if.sv */
// ~~~~~~~~~~~~~~~~~~~~
// l2 array access bundle
// controller side index and write controls,
// tag and data read results back
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

interface l2_array_if #(
    parameter int unsigned INDEX_BITS = 4
);
    import l2_cache_pkg::*;

    localparam int unsigned TAG_WIDTH = ADDR_WIDTH - INDEX_BITS - OFFSET_BITS;

    logic [INDEX_BITS-1:0] index;       // addressed set, shared by both arrays

    logic                  tag_we;      // tag write strobe
    logic [TAG_WIDTH-1:0]  tag_wtag;
    logic                  tag_wvalid;
    logic                  tag_wdirty;

    logic [TAG_WIDTH-1:0]  tag_rtag;    // combinational on index
    logic                  tag_rvalid;
    logic                  tag_rdirty;

    logic                  data_we;     // line write strobe
    line_t                 data_wline;
    line_t                 data_rline;  // combinational on index

    modport ctrl (
        output index, tag_we, tag_wtag, tag_wvalid, tag_wdirty, data_we, data_wline,
        input  tag_rtag, tag_rvalid, tag_rdirty, data_rline
    );

    modport tags (
        input  index, tag_we, tag_wtag, tag_wvalid, tag_wdirty,
        output tag_rtag, tag_rvalid, tag_rdirty
    );

    modport data (
        input  index, data_we, data_wline,
        output data_rline
    );

endinterface

`default_nettype wire

/* source/l2_tag_store.sv */
// ~~~~~~~~~~~~~~~~~~~~
// l2 tag store
// tag, valid and dirty per set, direct mapped
// combinational read, write on clock edge
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module l2_tag_store #(
    parameter int unsigned INDEX_BITS = 4
) (
    input  logic        clk_i,
    input  logic        rst_ni,
    l2_array_if.tags    arr
);
    import l2_cache_pkg::*;

    localparam int unsigned TAG_WIDTH = ADDR_WIDTH - INDEX_BITS - OFFSET_BITS;
    localparam int unsigned NUM_SETS  = 2 ** INDEX_BITS;

    logic [TAG_WIDTH-1:0] tag_q [NUM_SETS];  // stored tags
    logic [NUM_SETS-1:0]  valid_q;           // one bit per set
    logic [NUM_SETS-1:0]  dirty_q;

    // status bits, cleared so every set starts invalid
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (arr.tag_we) begin
            valid_q[arr.index] <= arr.tag_wvalid;
            dirty_q[arr.index] <= arr.tag_wdirty;
        end
    end

    // tag bits, meaningless until valid is set
    always_ff @(posedge clk_i) begin
        if (arr.tag_we) begin
            tag_q[arr.index] <= arr.tag_wtag;
        end
    end

    // read port follows the index directly
    assign arr.tag_rtag   = tag_q[arr.index];
    assign arr.tag_rvalid = valid_q[arr.index];
    assign arr.tag_rdirty = dirty_q[arr.index];

endmodule

`default_nettype wire

/* source/l2_data_store.sv */
// ~~~~~~~~~~~~~~~~~~~~
// l2 data store
// one line per set, combinational read,
// write on clock edge
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module l2_data_store #(
    parameter int unsigned INDEX_BITS = 4
) (
    input  logic        clk_i,
    l2_array_if.data    arr
);
    import l2_cache_pkg::*;

    localparam int unsigned NUM_SETS = 2 ** INDEX_BITS;

    line_t line_q [NUM_SETS];  // line storage

    // write on strobe, index shared with the tag array
    always_ff @(posedge clk_i) begin
        if (arr.data_we) begin
            line_q[arr.index] <= arr.data_wline;
        end
    end

    assign arr.data_rline = line_q[arr.index];  // async read

endmodule

`default_nettype wire

/* source/l2_access_counters.sv */
// ~~~~~~~~~~~~~~~~~~~~
// l2 statistics counters
// counts accesses and misses, hits are
// the difference of the two
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module l2_access_counters (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    input  logic                 access_i,      // one pulse per accepted request
    input  logic                 miss_i,        // one pulse per missing compare
    output l2_cache_pkg::count_t acc_count_o,
    output l2_cache_pkg::count_t miss_count_o,
    output l2_cache_pkg::count_t hit_count_o
);
    import l2_cache_pkg::*;

    count_t acc_q;
    count_t miss_q;

    // counters wrap silently at full scale
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            acc_q  <= '0;
            miss_q <= '0;
        end else begin
            if (access_i) acc_q <= acc_q + count_t'(1);
            if (miss_i) miss_q <= miss_q + count_t'(1);
        end
    end

    assign acc_count_o  = acc_q;
    assign miss_count_o = miss_q;
    // each access misses at most once, refill compare always hits
    assign hit_count_o  = acc_q - miss_q;

endmodule

`default_nettype wire

/* source/l2_cache_controller.sv */
// ~~~~~~~~~~~~~~~~~~~~
// l2 cache controller
// direct mapped write-back FSM: tag compare,
// victim write-back and line allocate,
// drives the arrays and the memory request
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module l2_cache_controller #(
    parameter int unsigned INDEX_BITS = 4
) (
    input  logic                clk_i,
    input  logic                rst_ni,
    // requester side
    input  logic                req_valid_i,
    input  logic                req_we_i,
    input  l2_cache_pkg::addr_t req_addr_i,
    input  l2_cache_pkg::line_t req_wdata_i,
    output logic                resp_valid_o,
    output l2_cache_pkg::line_t resp_rdata_o,
    output logic                busy_o,
    // memory side
    output logic                mem_req_valid_o,
    output logic                mem_req_we_o,
    output l2_cache_pkg::addr_t mem_req_addr_o,
    output l2_cache_pkg::line_t mem_req_wdata_o,
    input  logic                mem_ready_i,
    input  l2_cache_pkg::line_t mem_rdata_i,
    // arrays and statistics
    l2_array_if.ctrl            arr,
    output logic                access_pulse_o,
    output logic                miss_pulse_o
);
    import l2_cache_pkg::*;

    localparam int unsigned TAG_WIDTH = ADDR_WIDTH - INDEX_BITS - OFFSET_BITS;
    localparam int unsigned TAG_LSB   = OFFSET_BITS + INDEX_BITS;

    cache_state_e state_q, state_d;

    logic [TAG_WIDTH-1:0]  req_tag;    // tag field of the request
    logic [INDEX_BITS-1:0] req_index;  // set field of the request
    logic                  hit;
    logic                  victim_dirty;

    addr_t wb_addr_q;  // victim address, old tag with request index
    line_t wb_line_q;  // victim line, captured before the tag is replaced

    assign req_tag   = req_addr_i[ADDR_WIDTH-1:TAG_LSB];
    assign req_index = req_addr_i[TAG_LSB-1:OFFSET_BITS];

    assign hit          = arr.tag_rvalid && (arr.tag_rtag == req_tag);
    assign victim_dirty = arr.tag_rvalid && arr.tag_rdirty;

    // next state and array controls
    always_comb begin
        state_d        = state_q;  // hold by default
        arr.index      = req_index;
        arr.tag_we     = 1'b0;
        arr.tag_wtag   = req_tag;
        arr.tag_wvalid = 1'b1;
        arr.tag_wdirty = req_we_i;  // a write always leaves the line dirty
        arr.data_we    = 1'b0;
        arr.data_wline = req_wdata_i;
        resp_valid_o   = 1'b0;
        busy_o         = 1'b0;
        access_pulse_o = 1'b0;
        miss_pulse_o   = 1'b0;

        case (state_q)
            IDLE: begin
                if (req_valid_i) begin
                    access_pulse_o = 1'b1;  // request accepted
                    state_d        = COMPARE_TAG;
                end
            end
            COMPARE_TAG: begin
                if (hit) begin
                    resp_valid_o = 1'b1;
                    if (req_we_i) begin
                        // write hit, store word and mark dirty
                        arr.tag_we     = 1'b1;
                        arr.tag_wdirty = 1'b1;
                        arr.data_we    = 1'b1;
                    end
                    state_d = IDLE;
                end else begin
                    busy_o       = 1'b1;
                    miss_pulse_o = 1'b1;
                    arr.tag_we   = 1'b1;  // claim the set for the new tag
                    // dirty victim goes out first
                    state_d = victim_dirty ? WRITE_BACK : ALLOCATE;
                end
            end
            ALLOCATE: begin
                busy_o = 1'b1;
                if (mem_ready_i) begin
                    arr.data_we = 1'b1;
                    // write miss keeps its own data
                    arr.data_wline = req_we_i ? req_wdata_i : mem_rdata_i;
                    state_d        = COMPARE_TAG;  // re-compare, hits now
                end
            end
            WRITE_BACK: begin
                busy_o = 1'b1;
                if (mem_ready_i) begin
                    state_d = ALLOCATE;  // victim accepted, fetch new line
                end
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // victim capture on the missing compare
    always_ff @(posedge clk_i) begin
        if (state_q == COMPARE_TAG && !hit) begin
            wb_addr_q <= {arr.tag_rtag, req_index, req_addr_i[OFFSET_BITS-1:0]};
            wb_line_q <= arr.data_rline;
        end
    end

    assign resp_rdata_o = arr.data_rline;  // valid with resp_valid_o

    // memory request held stable for the whole wait
    assign mem_req_valid_o = (state_q == ALLOCATE) || (state_q == WRITE_BACK);
    assign mem_req_we_o    = (state_q == WRITE_BACK);
    assign mem_req_addr_o  = (state_q == WRITE_BACK) ? wb_addr_q : req_addr_i;
    assign mem_req_wdata_o = wb_line_q;

endmodule

`default_nettype wire

/* source/l2_cache_top.sv */
// ~~~~~~~~~~~~~~~~~~~~
// l2 cache top level
// controller, tag store, data store and
// statistics counters behind plain ports
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module l2_cache_top #(
    parameter int unsigned INDEX_BITS = 4
) (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    // requester
    input  logic                 req_valid_i,
    input  logic                 req_we_i,
    input  l2_cache_pkg::addr_t  req_addr_i,
    input  l2_cache_pkg::line_t  req_wdata_i,
    output logic                 resp_valid_o,
    output l2_cache_pkg::line_t  resp_rdata_o,
    output logic                 busy_o,
    // backing memory
    output logic                 mem_req_valid_o,
    output logic                 mem_req_we_o,
    output l2_cache_pkg::addr_t  mem_req_addr_o,
    output l2_cache_pkg::line_t  mem_req_wdata_o,
    input  logic                 mem_ready_i,
    input  l2_cache_pkg::line_t  mem_rdata_i,
    // statistics
    output l2_cache_pkg::count_t acc_count_o,
    output l2_cache_pkg::count_t hit_count_o,
    output l2_cache_pkg::count_t miss_count_o
);

    logic access_pulse;  // controller to counters
    logic miss_pulse;

    l2_array_if #(.INDEX_BITS(INDEX_BITS)) arr_if ();

    l2_cache_controller #(.INDEX_BITS(INDEX_BITS)) l2_cache_controller_i (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .req_valid_i     (req_valid_i),
        .req_we_i        (req_we_i),
        .req_addr_i      (req_addr_i),
        .req_wdata_i     (req_wdata_i),
        .resp_valid_o    (resp_valid_o),
        .resp_rdata_o    (resp_rdata_o),
        .busy_o          (busy_o),
        .mem_req_valid_o (mem_req_valid_o),
        .mem_req_we_o    (mem_req_we_o),
        .mem_req_addr_o  (mem_req_addr_o),
        .mem_req_wdata_o (mem_req_wdata_o),
        .mem_ready_i     (mem_ready_i),
        .mem_rdata_i     (mem_rdata_i),
        .arr             (arr_if.ctrl),
        .access_pulse_o  (access_pulse),
        .miss_pulse_o    (miss_pulse)
    );

    l2_tag_store #(.INDEX_BITS(INDEX_BITS)) l2_tag_store_i (
        .clk_i  (clk_i),
        .rst_ni (rst_ni),
        .arr    (arr_if.tags)
    );

    l2_data_store #(.INDEX_BITS(INDEX_BITS)) l2_data_store_i (
        .clk_i (clk_i),
        .arr   (arr_if.data)
    );

    l2_access_counters l2_access_counters_i (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .access_i     (access_pulse),
        .miss_i       (miss_pulse),
        .acc_count_o  (acc_count_o),
        .miss_count_o (miss_count_o),
        .hit_count_o  (hit_count_o)
    );

endmodule

`default_nettype wire

/* bench/l2_clock_gen.sv */
// ~~~~~~~~~~~~~~~~~~~~
// testbench clock and reset
// 100 ns clock, reset held low for 8 cycles
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module l2_clock_gen (
    output logic clk_o,
    output logic rst_no
);
    initial begin
        clk_o = 1'b0;
        forever #50 clk_o = ~clk_o;  // half period
    end

    initial begin
        rst_no = 1'b0;
        repeat (8) @(posedge clk_o);
        rst_no <= 1'b1;  // released on a rising edge
    end
endmodule

`default_nettype wire

/* bench/tb_l2_cache.sv */
// ~~~~~~~~~~~~~~~~~~~~
// l2 cache testbench
// memory model with random latency and a per set
// reference model driven by directed then random requests
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module tb_l2_cache;
    import l2_cache_pkg::*;

    localparam int unsigned INDEX_BITS = 4;
    localparam int unsigned TAG_LSB    = OFFSET_BITS + INDEX_BITS;
    localparam int unsigned TIMEOUT    = 64;             // cycles allowed per wait
    localparam line_t       FILL_KEY   = 32'h5ac3_0f96;  // pattern of untouched words

    logic   clk, rst_n;
    logic   req_valid_i, req_we_i, resp_valid_o, busy_o;
    logic   mem_req_valid_o, mem_req_we_o, mem_ready_i;
    addr_t  req_addr_i, mem_req_addr_o;
    line_t  req_wdata_i, resp_rdata_o, mem_req_wdata_o, mem_rdata_i;
    count_t acc_count_o, hit_count_o, miss_count_o;

    line_t mem_store [addr_t];  // backing memory by word aligned key
    line_t ref_mem [addr_t];    // last value written per word
    bit    ref_valid [2**INDEX_BITS];
    bit    ref_dirty [2**INDEX_BITS];
    logic  [ADDR_WIDTH-TAG_LSB-1:0] ref_tag [2**INDEX_BITS];
    line_t ref_line [2**INDEX_BITS];
    logic  txn_we_q [$];        // memory requests as the model saw them
    addr_t txn_addr_q [$];
    line_t txn_data_q [$];
    int unsigned n_acc, n_miss;  // expected counter values
    logic [31:0] lfsr = 32'h9a9d;

    l2_clock_gen clock_gen_i (.clk_o(clk), .rst_no(rst_n));

    l2_cache_top #(.INDEX_BITS(INDEX_BITS)) l2_cache_top_i (.*, .clk_i(clk), .rst_ni(rst_n));

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // taps 32 22 2 1
    endfunction

    // one lfsr step per bit taken
    task automatic draw_bits(input int n, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < n; i++) begin
            lfsr  = lfsr_next(lfsr);
            value = {value[30:0], lfsr[0]};
        end
    endtask

    function automatic addr_t word_of(input addr_t a);
        return {a[ADDR_WIDTH-1:OFFSET_BITS], OFFSET_BITS'(0)};  // offset ignored
    endfunction

    // never written words read as their address xor a key
    function automatic line_t read_word(const ref line_t store [addr_t], input addr_t a);
        return store.exists(word_of(a)) ? store[word_of(a)] : word_of(a) ^ FILL_KEY;
    endfunction

    task automatic report_failure(input string what);
        cache_state_e state;
        state = l2_cache_top_i.l2_cache_controller_i.state_q;  // debug only
        $display("** Error at %0t ns: %s (controller in %s)", $time, what, state.name());
        $display("Test FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        assert (actual === expected)
        else report_failure($sformatf("%s is %h, expected %h", name, actual, expected));
    endtask

    // request fields frozen while the memory stalls
    task automatic check_held(input logic we, input addr_t addr, input line_t wdata);
        check_value("mem_req_valid_o", mem_req_valid_o, 1'b1);
        check_value("mem_req_we_o", mem_req_we_o, we);
        check_value("mem_req_addr_o", mem_req_addr_o, addr);
        check_value("mem_req_wdata_o", mem_req_wdata_o, wdata);
        check_value("busy_o", busy_o, 1'b1);              // miss in progress
        check_value("resp_valid_o", resp_valid_o, 1'b0);  // no answer mid miss
    endtask

    // memory model answers each request after 0 to 7 cycles
    initial begin : memory_model
        logic [31:0] delay;
        logic        we;
        addr_t       addr;
        line_t       wdata;
        mem_ready_i = 1'b0;
        mem_rdata_i = '0;
        forever begin
            @(negedge clk);
            if (rst_n === 1'b1 && mem_req_valid_o === 1'b1) begin
                we    = mem_req_we_o;
                addr  = mem_req_addr_o;
                wdata = mem_req_wdata_o;
                txn_we_q.push_back(we);
                txn_addr_q.push_back(addr);
                txn_data_q.push_back(wdata);
                draw_bits(3, delay);
                repeat (delay) begin
                    @(negedge clk);
                    check_held(we, addr, wdata);
                end
                @(posedge clk);
                mem_ready_i <= 1'b1;  // single cycle pulse
                mem_rdata_i <= read_word(mem_store, addr);
                if (we) mem_store[word_of(addr)] = wdata;
                @(negedge clk);
                check_held(we, addr, wdata);
                @(posedge clk);
                mem_ready_i <= 1'b0;
            end
        end
    end

    // one request predicted from the reference model and checked at the response
    task automatic run_request(input logic we, input addr_t addr, input line_t wdata);
        logic [INDEX_BITS-1:0]         idx;
        logic [ADDR_WIDTH-TAG_LSB-1:0] tag;
        logic  hit;
        logic  evict;
        addr_t victim;
        line_t expected;
        int    cycles;
        idx      = addr[TAG_LSB-1:OFFSET_BITS];
        tag      = addr[ADDR_WIDTH-1:TAG_LSB];
        hit      = ref_valid[idx] && (ref_tag[idx] == tag);
        evict    = !hit && ref_valid[idx] && ref_dirty[idx];  // dirty victim leaves first
        victim   = {ref_tag[idx], idx, addr[OFFSET_BITS-1:0]};  // old tag in the same set
        expected = read_word(ref_mem, addr);
        n_acc++;
        n_miss += hit ? 0 : 1;
        @(posedge clk);
        req_valid_i <= 1'b1;
        req_we_i    <= we;
        req_addr_i  <= addr;
        req_wdata_i <= wdata;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (cycles > TIMEOUT) report_failure("no response to a request");
        end while (!resp_valid_o);
        if (!we) check_value("resp_rdata_o", resp_rdata_o, expected);
        if (hit) check_value("hit latency", cycles, 2);  // sampled then answered
        check_value("busy_o", busy_o, 1'b0);  // answered from a hitting compare
        check_value("memory requests", txn_we_q.size(), hit ? 0 : (evict ? 2 : 1));
        if (evict) begin
            check_value("write-back mem_req_we_o", txn_we_q.pop_front(), 1'b1);
            check_value("write-back mem_req_addr_o", txn_addr_q.pop_front(), victim);
            check_value("write-back mem_req_wdata_o", txn_data_q.pop_front(), ref_line[idx]);
        end
        if (!hit) begin
            check_value("refill mem_req_we_o", txn_we_q.pop_front(), 1'b0);
            check_value("refill mem_req_addr_o", txn_addr_q.pop_front(), addr);
            void'(txn_data_q.pop_front());
        end
        check_value("acc_count_o", acc_count_o, n_acc);
        check_value("miss_count_o", miss_count_o, n_miss);
        check_value("hit_count_o", hit_count_o, n_acc - n_miss);
        @(posedge clk);
        req_valid_i <= 1'b0;  // dropped at the edge that sees the pulse
        if (we) ref_mem[word_of(addr)] = wdata;
        ref_line[idx]  = we ? wdata : expected;
        ref_dirty[idx] = we || (hit && ref_dirty[idx]);  // writes always dirty
        ref_valid[idx] = 1'b1;
        ref_tag[idx]   = tag;
    endtask

    initial begin : stimulus
        logic [31:0] addr_r;
        logic [31:0] we_r;
        logic [31:0] data_r;
        int          waited;
        req_valid_i = 1'b0;
        req_we_i    = 1'b0;
        req_addr_i  = '0;
        req_wdata_i = '0;
        waited      = 0;
        while (rst_n !== 1'b1) begin
            @(negedge clk);
            waited++;
            if (waited > TIMEOUT) report_failure("reset was never released");
        end
        @(negedge clk);
        check_value("resp_valid_o", resp_valid_o, 1'b0);
        check_value("mem_req_valid_o", mem_req_valid_o, 1'b0);
        check_value("busy_o", busy_o, 1'b0);
        check_value("acc_count_o", acc_count_o, 0);
        check_value("miss_count_o", miss_count_o, 0);
        check_value("hit_count_o", hit_count_o, 0);
        // set 3 with tags 0 to 2
        run_request(1'b0, 32'h0000_000c, '0);            // clean miss
        run_request(1'b0, 32'h0000_000c, '0);            // read hit
        run_request(1'b1, 32'h0000_000c, 32'hcafe_0001); // write hit leaves line dirty
        run_request(1'b0, 32'h0000_000e, '0);            // hit through another offset
        run_request(1'b0, 32'h0000_004c, '0);            // dirty eviction
        run_request(1'b1, 32'h0000_008c, 32'hcafe_0002); // write miss over a clean victim
        run_request(1'b0, 32'h0000_000c, '0);            // written-back word returns
        run_request(1'b0, 32'h0000_008c, '0);
        repeat (200) begin
            draw_bits(6, addr_r);
            draw_bits(1, we_r);
            draw_bits(32, data_r);
            // four tags compete for sets 0 to 3
            run_request(we_r[0], {24'h000010, addr_r[5:4], 2'b00, addr_r[3:0]}, data_r);
        end
        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

/* sources.f */
source/l2_cache_pkg.sv
source/l2_array_if.sv
source/l2_tag_store.sv
source/l2_data_store.sv
source/l2_access_counters.sv
source/l2_cache_controller.sv
source/l2_cache_top.sv
bench/l2_clock_gen.sv
bench/tb_l2_cache.sv

/* Bender.yml */
package:
  name: l2_cache

sources:
  - files:
      - source/l2_cache_pkg.sv
      - source/l2_array_if.sv
      - source/l2_tag_store.sv
      - source/l2_data_store.sv
      - source/l2_access_counters.sv
      - source/l2_cache_controller.sv
      - source/l2_cache_top.sv
  - target: test
    files:
      - bench/l2_clock_gen.sv
      - bench/tb_l2_cache.sv
